// File: hw/gb_defines.svh
`ifndef GB_DEFINES_SVH
`define GB_DEFINES_SVH

// --------------------
// bus widths
// --------------------
`define GB_DATA_W        8
`define GB_ADDR_W        16
`define GB_WRAM_AW       15     // 32 KiB, eight 4 KiB banks
`define GB_WRAM_BW       3      // bank number bits
`define GB_WRAM_PAGE_AW  12     // bytes per bank, as address bits
`define GB_ZP_AW         7
`define GB_JOY_W         4      // p10..p13 input lines

// --------------------
// interrupts
// --------------------
`define GB_IRQ_N         5      // vblank, lcd, timer, serial, joypad
`define GB_IRQ_VEC_BASE  8'h40
`define GB_IRQ_VEC_STEP  8'h08

// --------------------
// io page and register map
// --------------------
`define GB_IO_PAGE       8'hFF
`define GB_A_JOYP        16'hFF00
`define GB_A_IF          16'hFF0F
`define GB_A_KEY1        16'hFF4D
`define GB_A_SVBK        16'hFF70
`define GB_A_FF72        16'hFF72
`define GB_A_FF73        16'hFF73
`define GB_A_FF74        16'hFF74
`define GB_A_FF75        16'hFF75
`define GB_A_IE          16'hFFFF

// reset values
`define GB_SVBK_RST      3'd1   // bank 0 is never mapped at d000
`define GB_P54_RST       2'b00

// unmapped reads
`define GB_OPEN_BUS      8'hFF

`endif

// File: hw/gb_pkg.sv
`include "gb_defines.svh"

package gb_pkg;

	// io page view of an address, register number in the low byte
	typedef struct packed {
		logic [7:0] page;
		logic [7:0] offset;
	} cpu_io_addr_t;

	// same 16 bits, two decodes
	typedef union packed {
		logic [`GB_ADDR_W-1:0] flat;    // memory regions
		cpu_io_addr_t          io;      // ffxx registers, zero page index
	} cpu_addr_u;

endpackage

// File: hw/gb_bus_ctrl.sv
`timescale 1ns/100ps
`include "gb_defines.svh"

module gb_bus_ctrl import gb_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset_ss,
	// cpu side
	input  cpu_addr_u              cpu_addr_i,
	input  logic [`GB_DATA_W-1:0]  cpu_do_i,
	input  logic                   cpu_wr_n_i,
	input  logic                   cpu_iorq_n_i,
	input  logic                   cpu_m1_n_i,
	// read words from the units
	input  logic [`GB_DATA_W-1:0]  irq_vec_i,
	input  logic [`GB_DATA_W-1:0]  ie_i,
	input  logic [`GB_IRQ_N-1:0]   if_i,
	input  logic [`GB_DATA_W-1:0]  wram_q_i,
	input  logic [`GB_DATA_W-1:0]  zp_q_i,
	input  logic [`GB_WRAM_BW-1:0] svbk_i,
	input  logic [`GB_DATA_W-1:0]  joy_q_i,
	input  logic [`GB_DATA_W-1:0]  key1_q_i,
	input  logic [`GB_DATA_W-1:0]  spare_q_i,
	// strobes and selects
	output logic                   wr_stb_o,
	output logic                   irq_ack_o,
	output logic                   sel_ie_o,
	output logic                   sel_if_o,
	output logic                   sel_joy_o,
	output logic                   sel_key1_o,
	output logic                   sel_spare_o,
	output logic [1:0]             spare_idx_o,
	output logic                   sel_svbk_o,
	output logic                   sel_wram_o,
	output logic                   sel_zp_o,
	output logic [`GB_DATA_W-1:0]  cpu_di_o
);

	// register numbers inside the ffxx page
	localparam logic [7:0] OFS_JOYP = 8'(`GB_A_JOYP);
	localparam logic [7:0] OFS_IF   = 8'(`GB_A_IF);
	localparam logic [7:0] OFS_KEY1 = 8'(`GB_A_KEY1);
	localparam logic [7:0] OFS_SVBK = 8'(`GB_A_SVBK);
	localparam logic [7:0] OFS_FF72 = 8'(`GB_A_FF72);
	localparam logic [7:0] OFS_FF75 = 8'(`GB_A_FF75);
	localparam logic [7:0] OFS_IE   = 8'(`GB_A_IE);

	logic       wr_n_q;     // wr_n one cycle ago
	logic       is_io;
	logic [7:0] ofs;

	// --------------------
	// write edge
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			wr_n_q <= 1'b1;
		end else begin
			wr_n_q <= cpu_wr_n_i;
		end
	end

	assign wr_stb_o  = wr_n_q & ~cpu_wr_n_i;     // first low cycle only
	assign irq_ack_o = ~cpu_iorq_n_i & ~cpu_m1_n_i;

	// --------------------
	// decode
	// --------------------
	assign is_io = (cpu_addr_i.io.page == `GB_IO_PAGE);
	assign ofs   = cpu_addr_i.io.offset;

	// c000-fdff, e000 upward echoes c000
	assign sel_wram_o = (cpu_addr_i.flat[15:14] == 2'b11) && (cpu_addr_i.flat[13:9] != 5'h1F);

	assign sel_joy_o   = is_io && (ofs == OFS_JOYP);
	assign sel_if_o    = is_io && (ofs == OFS_IF);
	assign sel_key1_o  = is_io && (ofs == OFS_KEY1);
	assign sel_svbk_o  = is_io && (ofs == OFS_SVBK);
	assign sel_spare_o = is_io && (ofs >= OFS_FF72) && (ofs <= OFS_FF75);
	assign sel_ie_o    = is_io && (ofs == OFS_IE);
	assign sel_zp_o    = is_io && ofs[7] && (ofs != OFS_IE);   // ff80-fffe

	assign spare_idx_o = ofs[1:0] - 2'd2;       // ff72 -> 0 .. ff75 -> 3

	// --------------------
	// read mux
	// --------------------
	always_comb begin
		if (irq_ack_o) begin
			cpu_di_o = irq_vec_i;               // vector fetch wins
		end else if (!cpu_wr_n_i) begin
			cpu_di_o = cpu_do_i;                // cpu drives the shared bus
		end else if (sel_if_o) begin
			cpu_di_o = {3'b111, if_i};
		end else if (sel_ie_o) begin
			cpu_di_o = ie_i;
		end else if (sel_svbk_o) begin
			cpu_di_o = {5'h1F, svbk_i};
		end else if (sel_joy_o) begin
			cpu_di_o = joy_q_i;
		end else if (sel_key1_o) begin
			cpu_di_o = key1_q_i;
		end else if (sel_spare_o) begin
			cpu_di_o = spare_q_i;
		end else if (sel_wram_o) begin
			cpu_di_o = wram_q_i;                // one cycle behind the address
		end else if (sel_zp_o) begin
			cpu_di_o = zp_q_i;
		end else begin
			cpu_di_o = `GB_OPEN_BUS;
		end
	end

endmodule

// File: hw/gb_irq_ctrl.sv
`timescale 1ns/100ps
`include "gb_defines.svh"

module gb_irq_ctrl (
	input  logic                  clk_sys,
	input  logic                  reset_ss,
	input  logic                  wr_stb_i,
	input  logic                  sel_ie_i,
	input  logic                  sel_if_i,
	input  logic [`GB_DATA_W-1:0] cpu_do_i,
	input  logic                  irq_ack_i,
	input  logic [`GB_IRQ_N-2:0]  irq_req_i,   // vblank, lcd, timer, serial
	input  logic [`GB_JOY_W-1:0]  joy_din_i,   // active low keys
	output logic [`GB_DATA_W-1:0] ie_o,
	output logic [`GB_IRQ_N-1:0]  if_o,
	output logic [`GB_DATA_W-1:0] irq_vec_o,
	output logic                  irq_n_o
);

	logic [`GB_DATA_W-1:0] ie_q;           // all 8 bits kept, low 5 used
	logic [`GB_IRQ_N-1:0]  if_q;
	logic [`GB_IRQ_N-2:0]  req_q;          // request lines last cycle
	logic [`GB_JOY_W-1:0]  joy_d1;
	logic [`GB_JOY_W-1:0]  joy_d2;
	logic                  ack_q;

	logic [`GB_IRQ_N-1:0]  pend;           // pending and enabled
	logic [`GB_IRQ_N-1:0]  clr;            // one-hot, lowest pending
	logic [`GB_IRQ_N-1:0]  set;
	logic                  joy_fall;
	logic                  ack_fall;

	assign pend     = ie_q[`GB_IRQ_N-1:0] & if_q;
	assign joy_fall = |(~joy_d1 & joy_d2);    // any line went high to low
	assign set      = {joy_fall, irq_req_i & ~req_q};
	assign ack_fall = ack_q & ~irq_ack_i;

	// --------------------
	// priority
	// --------------------
	// bit 0 is highest, so scan downward and let the lowest win
	always_comb begin
		irq_vec_o = 8'h00;
		clr       = '0;
		for (int i = `GB_IRQ_N - 1; i >= 0; i--) begin
			if (pend[i]) begin
				irq_vec_o = 8'(`GB_IRQ_VEC_BASE + `GB_IRQ_VEC_STEP * i);
				clr       = '0;
				clr[i]    = 1'b1;
			end
		end
	end

	assign irq_n_o = ~|pend;

	// --------------------
	// ie / if
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			ie_q   <= '0;
			if_q   <= '0;
			req_q  <= '0;
			joy_d1 <= '1;                       // keys idle high
			joy_d2 <= '1;
			ack_q  <= 1'b0;
		end else begin
			req_q  <= irq_req_i;
			joy_d1 <= joy_din_i;
			joy_d2 <= joy_d1;
			ack_q  <= irq_ack_i;

			// edges set, end of ack clears the serviced one
			if_q <= (if_q | set) & ~(ack_fall ? clr : '0);

			// cpu writes override the captured edges
			if (wr_stb_i && sel_if_i) begin
				if_q <= cpu_do_i[`GB_IRQ_N-1:0];
			end
			if (wr_stb_i && sel_ie_i) begin
				ie_q <= cpu_do_i;
			end
		end
	end

	assign ie_o = ie_q;
	assign if_o = if_q;

endmodule

// File: hw/gb_work_ram.sv
`timescale 1ns/100ps
`include "gb_defines.svh"

module gb_work_ram import gb_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset_ss,
	input  logic                   wr_stb_i,
	input  logic                   sel_wram_i,
	input  logic                   sel_zp_i,
	input  logic                   sel_svbk_i,
	input  cpu_addr_u              cpu_addr_i,
	input  logic [`GB_DATA_W-1:0]  cpu_do_i,
	output logic [`GB_DATA_W-1:0]  wram_q_o,
	output logic [`GB_DATA_W-1:0]  zp_q_o,
	output logic [`GB_WRAM_BW-1:0] svbk_o
);

	logic [`GB_DATA_W-1:0]  wram_mem [0:(1 << `GB_WRAM_AW)-1];
	logic [`GB_DATA_W-1:0]  zp_mem   [0:(1 << `GB_ZP_AW)-1];

	logic [`GB_WRAM_BW-1:0] svbk_q;
	logic [`GB_WRAM_BW-1:0] bank;
	logic [`GB_WRAM_AW-1:0] wram_addr;
	logic [`GB_ZP_AW-1:0]   zp_addr;

	// --------------------
	// svbk
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			svbk_q <= `GB_SVBK_RST;
		end else if (wr_stb_i && sel_svbk_i) begin
			if (cpu_do_i[`GB_WRAM_BW-1:0] == '0) begin
				svbk_q <= 3'd1;                 // 0 maps to bank 1
			end else begin
				svbk_q <= cpu_do_i[`GB_WRAM_BW-1:0];
			end
		end
	end

	assign svbk_o = svbk_q;

	// c000-cfff always bank 0, d000-dfff switched
	assign bank      = cpu_addr_i.flat[`GB_WRAM_PAGE_AW] ? svbk_q : '0;
	assign wram_addr = {bank, cpu_addr_i.flat[`GB_WRAM_PAGE_AW-1:0]};

	// ff80-fffe, index from the io low byte
	assign zp_addr = cpu_addr_i.io.offset[`GB_ZP_AW-1:0];

	// --------------------
	// arrays
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (wr_stb_i && sel_wram_i) begin
			wram_mem[wram_addr] <= cpu_do_i;
		end
		wram_q_o <= wram_mem[wram_addr];        // sync read
	end

	always_ff @(posedge clk_sys) begin
		if (wr_stb_i && sel_zp_i) begin
			zp_mem[zp_addr] <= cpu_do_i;
		end
		zp_q_o <= zp_mem[zp_addr];
	end

endmodule

// File: hw/gb_sys_regs.sv
`timescale 1ns/100ps
`include "gb_defines.svh"

module gb_sys_regs (
	input  logic                  clk_sys,
	input  logic                  reset_ss,
	input  logic                  wr_stb_i,
	input  logic                  sel_joy_i,
	input  logic                  sel_key1_i,
	input  logic                  sel_spare_i,
	input  logic [1:0]            spare_idx_i,   // 0 = ff72 .. 3 = ff75
	input  logic [`GB_DATA_W-1:0] cpu_do_i,
	input  logic [`GB_JOY_W-1:0]  joy_din_i,
	input  logic                  stop_i,
	output logic [`GB_DATA_W-1:0] joy_q_o,
	output logic [1:0]            joy_p54_o,
	output logic [`GB_DATA_W-1:0] key1_q_o,
	output logic [`GB_DATA_W-1:0] spare_q_o,
	output logic                  speed_o
);

	logic [1:0]            p54_q;
	logic                  prepare_q;     // armed for the next stop
	logic                  speed_q;       // 1 = double speed
	logic [`GB_DATA_W-1:0] ff72_q;
	logic [`GB_DATA_W-1:0] ff73_q;
	logic [`GB_DATA_W-1:0] ff74_q;
	logic [2:0]            ff75_q;        // bits 6..4 only

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			p54_q     <= `GB_P54_RST;
			prepare_q <= 1'b0;
			speed_q   <= 1'b0;
			ff72_q    <= '0;
			ff73_q    <= '0;
			ff74_q    <= '0;
			ff75_q    <= '0;
		end else begin
			if (wr_stb_i && sel_joy_i) p54_q <= cpu_do_i[5:4];
			if (wr_stb_i && sel_key1_i) prepare_q <= cpu_do_i[0];
			if (wr_stb_i && sel_spare_i) begin
				case (spare_idx_i)
					2'd0: ff72_q <= cpu_do_i;
					2'd1: ff73_q <= cpu_do_i;
					2'd2: ff74_q <= cpu_do_i;
					default: ff75_q <= cpu_do_i[6:4];
				endcase
			end
			// stop completes the switch, beats a same-cycle key1 write
			if (stop_i && prepare_q) begin
				speed_q   <= ~speed_q;
				prepare_q <= 1'b0;
			end
		end
	end

	// read words
	assign joy_q_o  = {2'b11, p54_q, joy_din_i};
	assign key1_q_o = {speed_q, 6'h3F, prepare_q};

	always_comb begin
		case (spare_idx_i)
			2'd0: spare_q_o = ff72_q;
			2'd1: spare_q_o = ff73_q;
			2'd2: spare_q_o = ff74_q;
			default: spare_q_o = {1'b1, ff75_q, 4'hF};
		endcase
	end

	assign joy_p54_o = p54_q;
	assign speed_o   = speed_q;    // status only, no clock change here

endmodule

// File: hw/gb_core.sv
`timescale 1ns/100ps
`include "gb_defines.svh"

module gb_core import gb_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset_ss,
	// cpu port
	input  cpu_addr_u             cpu_addr_i,
	input  logic [`GB_DATA_W-1:0] cpu_do_i,
	input  logic                  cpu_wr_n_i,
	input  logic                  cpu_iorq_n_i,
	input  logic                  cpu_m1_n_i,
	output logic [`GB_DATA_W-1:0] cpu_di_o,
	// system lines
	input  logic [`GB_IRQ_N-2:0]  irq_req_i,
	input  logic [`GB_JOY_W-1:0]  joy_din_i,
	input  logic                  stop_i,
	output logic                  irq_n_o,
	output logic [1:0]            joy_p54_o,
	output logic                  speed_o
);

	// strobes and selects
	logic                   wr_stb, irq_ack;
	logic                   sel_ie, sel_if, sel_joy, sel_key1, sel_spare;
	logic                   sel_svbk, sel_wram, sel_zp;
	logic [1:0]             spare_idx;
	// read words back to the mux
	logic [`GB_DATA_W-1:0]  irq_vec, irq_ie, wram_q, zp_q;
	logic [`GB_DATA_W-1:0]  joy_q, key1_q, spare_q;
	logic [`GB_IRQ_N-1:0]   irq_if;
	logic [`GB_WRAM_BW-1:0] svbk;

	gb_bus_ctrl u_bus (
		.clk_sys(clk_sys), .reset_ss(reset_ss),
		.cpu_addr_i(cpu_addr_i), .cpu_do_i(cpu_do_i), .cpu_wr_n_i(cpu_wr_n_i),
		.cpu_iorq_n_i(cpu_iorq_n_i), .cpu_m1_n_i(cpu_m1_n_i),
		.irq_vec_i(irq_vec), .ie_i(irq_ie), .if_i(irq_if), .wram_q_i(wram_q),
		.zp_q_i(zp_q), .svbk_i(svbk), .joy_q_i(joy_q), .key1_q_i(key1_q),
		.spare_q_i(spare_q),
		.wr_stb_o(wr_stb), .irq_ack_o(irq_ack), .sel_ie_o(sel_ie), .sel_if_o(sel_if),
		.sel_joy_o(sel_joy), .sel_key1_o(sel_key1), .sel_spare_o(sel_spare),
		.spare_idx_o(spare_idx), .sel_svbk_o(sel_svbk), .sel_wram_o(sel_wram),
		.sel_zp_o(sel_zp), .cpu_di_o(cpu_di_o)
	);

	gb_irq_ctrl u_irq (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .wr_stb_i(wr_stb),
		.sel_ie_i(sel_ie), .sel_if_i(sel_if), .cpu_do_i(cpu_do_i),
		.irq_ack_i(irq_ack), .irq_req_i(irq_req_i), .joy_din_i(joy_din_i),
		.ie_o(irq_ie), .if_o(irq_if), .irq_vec_o(irq_vec), .irq_n_o(irq_n_o)
	);

	gb_work_ram u_wram (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .wr_stb_i(wr_stb),
		.sel_wram_i(sel_wram), .sel_zp_i(sel_zp), .sel_svbk_i(sel_svbk),
		.cpu_addr_i(cpu_addr_i), .cpu_do_i(cpu_do_i),
		.wram_q_o(wram_q), .zp_q_o(zp_q), .svbk_o(svbk)
	);

	gb_sys_regs u_regs (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .wr_stb_i(wr_stb),
		.sel_joy_i(sel_joy), .sel_key1_i(sel_key1), .sel_spare_i(sel_spare),
		.spare_idx_i(spare_idx), .cpu_do_i(cpu_do_i), .joy_din_i(joy_din_i),
		.stop_i(stop_i), .joy_q_o(joy_q), .joy_p54_o(joy_p54_o),
		.key1_q_o(key1_q), .spare_q_o(spare_q), .speed_o(speed_o)
	);

endmodule

// File: tests/gb_core_asserts.sv
`timescale 1ns/100ps
`include "gb_defines.svh"

module gb_core_asserts (
	input logic                   clk_sys,
	input logic                   reset_ss,
	input logic [`GB_WRAM_BW-1:0] svbk,
	input logic                   irq_n_o,
	input logic                   wr_stb
);

	// --------------------
	// bank and strobe
	// --------------------
	a_svbk_nonzero: assert property (@(posedge clk_sys) disable iff (reset_ss)
		svbk != '0) else $error("svbk holds bank 0");

	a_stb_single: assert property (@(posedge clk_sys) disable iff (reset_ss)
		wr_stb |=> !wr_stb) else $error("wr_stb high for two cycles");

	// first cycle out of reset
	a_irq_idle: assert property (@(posedge clk_sys)
		$fell(reset_ss) |-> irq_n_o) else $error("irq_n_o low right after reset");

endmodule

bind gb_core gb_core_asserts u_asserts (
	.clk_sys(clk_sys), .reset_ss(reset_ss), .svbk(svbk),
	.irq_n_o(irq_n_o), .wr_stb(wr_stb)
);

// File: tests/gb_core_tb.sv
`timescale 1ns/100ps
`include "gb_defines.svh"

module gb_core_tb;

	localparam int    CLK_PERIOD  = 40;
	localparam int    CASE_CYCLES = 12;     // cycle budget per case line
	localparam string CASE_FILE   = "tests/gb_core_cases.txt";

	logic                  clk_sys;
	logic                  reset_ss;
	logic [`GB_ADDR_W-1:0] cpu_addr;
	logic [`GB_DATA_W-1:0] cpu_do;
	logic                  cpu_wr_n;
	logic                  cpu_iorq_n;
	logic                  cpu_m1_n;
	logic [`GB_IRQ_N-2:0]  irq_req;
	logic [`GB_JOY_W-1:0]  joy_din;
	logic                  stop;
	logic [`GB_DATA_W-1:0] cpu_di;
	logic                  irq_n;
	logic [1:0]            joy_p54;
	logic                  speed;

	// one entry per case line
	logic [7:0]            op_q[$];
	logic [`GB_ADDR_W-1:0] addr_q[$];
	logic [`GB_DATA_W-1:0] val_q[$];
	int                    n_cases;
	int                    error_count;
	int                    check_count;

	gb_core dut (
		.clk_sys(clk_sys), .reset_ss(reset_ss),
		.cpu_addr_i(cpu_addr), .cpu_do_i(cpu_do), .cpu_wr_n_i(cpu_wr_n),
		.cpu_iorq_n_i(cpu_iorq_n), .cpu_m1_n_i(cpu_m1_n), .cpu_di_o(cpu_di),
		.irq_req_i(irq_req), .joy_din_i(joy_din), .stop_i(stop),
		.irq_n_o(irq_n), .joy_p54_o(joy_p54), .speed_o(speed)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// --------------------
	// helpers
	// --------------------
	task automatic next_cycle;    // inputs move 2 ns after the edge
		@(posedge clk_sys);
		#2;
	endtask

	task automatic check_val(input string name, input logic [7:0] act, input logic [7:0] exp);
		check_count++;
		if (act !== exp) begin
			$display("error at %0t: %s = %02h, expected %02h", $time, name, act, exp);
			error_count++;
		end
	endtask

	task automatic load_cases;
		int          fd;
		int          n;
		string       line;
		logic [7:0]  op;
		logic [15:0] addr;
		logic [7:0]  val;
		fd = $fopen(CASE_FILE, "r");
		if (fd == 0) begin
			$display("cannot open the case file %s", CASE_FILE);
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0 && line.getc(0) != "#") begin     // skip comment lines
					if ($sscanf(line, "%c %h %h", op, addr, val) == 3) begin
						op_q.push_back(op);
						addr_q.push_back(addr);
						val_q.push_back(val);
					end
				end
			end
			$fclose(fd);
		end
		n_cases = op_q.size();
	endtask

	// --------------------
	// bus and line tasks
	// --------------------
	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		next_cycle();
		cpu_addr = addr;
		cpu_do   = data;
		cpu_wr_n = 1'b0;
		repeat (3) next_cycle();                // strobe lands on the first edge
		cpu_wr_n = 1'b1;
		next_cycle();
		if (addr == `GB_A_JOYP) check_val("joy_p54_o", 8'(joy_p54), 8'(data[5:4]));
	endtask

	task automatic cpu_read(input logic [15:0] addr, input logic [7:0] exp);
		next_cycle();
		cpu_addr = addr;
		repeat (2) next_cycle();                // ram data one cycle late
		check_val("cpu_di_o", cpu_di, exp);
	endtask

	task automatic irq_pulse(input logic [3:0] bits, input logic [7:0] exp_n);
		next_cycle();
		irq_req = bits;
		next_cycle();
		irq_req = '0;
		repeat (2) next_cycle();
		check_val("irq_n_o", 8'(irq_n), exp_n);
	endtask

	task automatic joy_set(input logic [3:0] keys, input logic [7:0] exp_n);
		next_cycle();
		joy_din = keys;
		repeat (4) next_cycle();                // two-stage history plus capture
		check_val("irq_n_o", 8'(irq_n), exp_n);
	endtask

	task automatic irq_acknowledge(input logic [7:0] exp_vec);
		next_cycle();
		cpu_iorq_n = 1'b0;
		cpu_m1_n   = 1'b0;
		next_cycle();
		check_val("cpu_di_o", cpu_di, exp_vec);    // vector on the bus
		cpu_iorq_n = 1'b1;
		cpu_m1_n   = 1'b1;
		repeat (2) next_cycle();                // bit clears after ack falls
	endtask

	task automatic stop_pulse(input logic [7:0] exp_speed);
		next_cycle();
		stop = 1'b1;
		next_cycle();
		stop = 1'b0;
		next_cycle();
		check_val("speed_o", 8'(speed), exp_speed);
	endtask

	// --------------------
	// watchdog
	// --------------------
	initial begin
		wait (n_cases > 0);
		#(n_cases * CASE_CYCLES * CLK_PERIOD);
		$display("timeout: the cases did not finish within %0d cycles", n_cases * CASE_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		reset_ss    = 1'b1;
		cpu_addr    = '0;
		cpu_do      = '0;
		cpu_wr_n    = 1'b1;
		cpu_iorq_n  = 1'b1;
		cpu_m1_n    = 1'b1;
		irq_req     = '0;
		joy_din     = '1;                       // no key pressed
		stop        = 1'b0;
		error_count = 0;
		check_count = 0;
		load_cases();
		if (n_cases == 0) begin
			$display("no cases were read, nothing to run");
			$display("TEST FAILED");
			$finish;
		end else begin
			repeat (3) @(posedge clk_sys);
			#2 reset_ss = 1'b0;
			for (int i = 0; i < n_cases; i++) begin
				case (op_q[i])
					"W": cpu_write(addr_q[i], val_q[i]);
					"R": cpu_read(addr_q[i], val_q[i]);
					"I": irq_pulse(addr_q[i][3:0], val_q[i]);
					"J": joy_set(addr_q[i][3:0], val_q[i]);
					"A": irq_acknowledge(val_q[i]);
					"S": stop_pulse(val_q[i]);
					default: begin
						$display("case line %0d has an unknown opcode %c", i, op_q[i]);
						error_count++;
					end
				endcase
			end
			$display("%0d cases, %0d checks, %0d errors", n_cases, check_count, error_count);
			if (error_count == 0) begin
				$display("TEST OK");
			end else begin
				$display("TEST FAILED");
			end
			$finish;
		end
	end

endmodule

// File: tests/gb_core_cases.txt
# op addr/value expected, all hex; W addr data, R addr read value
# I req bits irq_n, J joy lines irq_n, A 00 vector, S 00 speed
W FF70 02
W D000 A2
W FF70 03
W D000 A3
W C000 5C
R FF70 FB
R D000 A3
R C000 5C
R E000 5C
W FF70 02
R D000 A2
R C000 5C
W FF70 00
R FF70 F9
W D000 B1
R D000 B1
# zero page and open bus
W FF80 11
W FFFE EE
R FF80 11
R FFFE EE
R FF03 FF
# interrupts, vblank and timer enabled
W FFFF 05
I 02 1
R FF0F E2
I 04 0
R FF0F E6
I 01 0
R FF0F E7
A 00 40
R FF0F E6
A 00 50
R FF0F E2
I 00 1
W FF0F 00
R FF0F E0
# joypad
W FF00 20
R FF00 EF
W FFFF 10
J 0E 0
R FF0F F0
R FF00 EE
A 00 60
R FF0F E0
J 0F 1
# key1 and spare registers
R FF4D 7E
W FF4D 01
R FF4D 7F
S 00 1
R FF4D FE
W FF4D 01
S 00 0
R FF4D 7E
S 00 0
W FF72 12
W FF73 34
W FF74 56
W FF75 00
R FF72 12
R FF73 34
R FF74 56
R FF75 8F
W FF75 5A
R FF75 DF

// File: filelist.f
+incdir+hw
hw/gb_pkg.sv
hw/gb_bus_ctrl.sv
hw/gb_irq_ctrl.sv
hw/gb_work_ram.sv
hw/gb_sys_regs.sv
hw/gb_core.sv
tests/gb_core_asserts.sv
tests/gb_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= gb_core_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
